// ==== hw/pulser_defs.svh ====
//////////////////////////////
// pulser register map
// sync byte, register addresses, reset
// defaults and the sample tag bit
//////////////////////////////
`ifndef PULSER_DEFS_SVH
`define PULSER_DEFS_SVH

`define PULSER_SYNC_BYTE 8'hAA

// register addresses
`define REG_PON_POFF   8'hD0
`define REG_PON        8'hE0
`define REG_POFF_H     8'hE1
`define REG_POFF_L     8'hE2
`define REG_DELAY_H    8'hE3
`define REG_DELAY_L    8'hE4
`define REG_ACQ_H      8'hE5
`define REG_ACQ_L      8'hE6
`define REG_PERIOD_U   8'hE7
`define REG_PERIOD_H   8'hE8
`define REG_PERIOD_L   8'hE9
`define REG_SOFT_TRIG  8'hEA
`define REG_CONT       8'hEB
`define REG_ADC_DIV    8'hED
`define REG_TRIG_COUNT 8'hEE
`define REG_PTR_RESET  8'hEF

// defaults after reset, in pll_clk128 cycles
`define DEF_PON_LEN    8'h14
`define DEF_PON_POFF   8'h0A
`define DEF_POFF_END   16'h00C8
`define DEF_ACQ_DELAY  16'h02BC
`define DEF_ACQ_END    16'h32C8
`define DEF_PERIOD     24'h0186A0
`define DEF_TRIG_COUNT 8'h0A   // shots per continuous burst
`define DEF_ADC_DIV    8'h03
`define DEF_CONTINUOUS 1'b0    // single shot

`define SAMPLE_TAG 1'b1        // top bit of every stored word

`endif

// ==== hw/pulser_pkg.sv ====
//////////////////////////////
// pulser types
// vector typedefs, received byte struct,
// sequencer config struct, sequencer states
//////////////////////////////
package pulser_pkg;

  typedef logic [7:0]  byte_t;        // spi bytes and 8-bit fields
  typedef logic [15:0] word16_t;      // timing values
  typedef logic [23:0] period_t;      // shot counter and period
  typedef logic [18:0] ram_addr_t;    // external sram address
  typedef logic [15:0] ram_word_t;
  typedef logic [9:0]  adc_sample_t;

  // one byte from the spi slave, valid for a single cycle
  typedef struct packed {
    byte_t data;
    logic  valid;
  } spi_rx_t;

  // everything the sequencer reads from the register file
  typedef struct packed {
    byte_t   pon_len;     // pulse-on length
    byte_t   pon_poff;    // start of damping
    word16_t poff_end;    // end of damping
    word16_t acq_delay;
    word16_t acq_end;
    period_t period;
    byte_t   trig_count;  // shots per burst
    logic    continuous;
  } seq_cfg_t;

  typedef enum logic {
    SEQ_IDLE,
    SEQ_SHOT
  } seq_state_e;

endpackage

// ==== hw/cfg_regs.sv ====
//////////////////////////////
// configuration registers
// sync / address / value byte parser,
// timing registers with defaults,
// soft trigger and pointer reset strobes
//////////////////////////////
`include "pulser_defs.svh"

module cfg_regs (
  input  logic                 pll_clk128,
  input  logic                 reset,
  input  pulser_pkg::spi_rx_t  i_spi_rx,
  output pulser_pkg::seq_cfg_t o_cfg,
  output pulser_pkg::byte_t    o_adc_div,
  output logic                 o_soft_trig,
  output logic                 o_ptr_reset
);
  import pulser_pkg::*;

  typedef enum logic [1:0] {
    PH_SYNC,
    PH_ADDR,
    PH_VALUE
  } phase_e;

  phase_e phase;
  byte_t  addr_q;     // held until the value byte arrives
  byte_t  rx_byte;
  logic   rx_valid;
  logic   wr_en;

  assign rx_byte  = i_spi_rx.data;
  assign rx_valid = i_spi_rx.valid;
  assign wr_en    = rx_valid && (phase == PH_VALUE);

  ////////////////////////////// byte parser
  always_ff @(posedge pll_clk128 or negedge reset) begin
    if (!reset) begin
      phase  <= PH_SYNC;
      addr_q <= '0;
    end else if (rx_valid) begin
      case (phase)
        PH_SYNC: begin
          if (rx_byte == `PULSER_SYNC_BYTE) phase <= PH_ADDR;  // anything else dropped
        end
        PH_ADDR: begin
          addr_q <= rx_byte;
          phase  <= PH_VALUE;
        end
        default: phase <= PH_SYNC;  // value byte consumed, back to sync
      endcase
    end
  end

  ////////////////////////////// register file
  always_ff @(posedge pll_clk128 or negedge reset) begin
    if (!reset) begin
      o_cfg.pon_len    <= `DEF_PON_LEN;
      o_cfg.pon_poff   <= `DEF_PON_POFF;
      o_cfg.poff_end   <= `DEF_POFF_END;
      o_cfg.acq_delay  <= `DEF_ACQ_DELAY;
      o_cfg.acq_end    <= `DEF_ACQ_END;
      o_cfg.period     <= `DEF_PERIOD;
      o_cfg.trig_count <= `DEF_TRIG_COUNT;
      o_cfg.continuous <= `DEF_CONTINUOUS;
      o_adc_div        <= `DEF_ADC_DIV;
      o_soft_trig      <= 1'b0;
      o_ptr_reset      <= 1'b0;
    end else begin
      o_soft_trig <= 1'b0;  // strobes last one cycle
      o_ptr_reset <= 1'b0;
      if (wr_en) begin
        case (addr_q)
          `REG_PON_POFF:   o_cfg.pon_poff          <= rx_byte;
          `REG_PON:        o_cfg.pon_len           <= rx_byte;
          `REG_POFF_H:     o_cfg.poff_end[15:8]    <= rx_byte;
          `REG_POFF_L:     o_cfg.poff_end[7:0]     <= rx_byte;
          `REG_DELAY_H:    o_cfg.acq_delay[15:8]   <= rx_byte;
          `REG_DELAY_L:    o_cfg.acq_delay[7:0]    <= rx_byte;
          `REG_ACQ_H:      o_cfg.acq_end[15:8]     <= rx_byte;
          `REG_ACQ_L:      o_cfg.acq_end[7:0]      <= rx_byte;
          `REG_PERIOD_U:   o_cfg.period[23:16]     <= rx_byte;
          `REG_PERIOD_H:   o_cfg.period[15:8]      <= rx_byte;
          `REG_PERIOD_L:   o_cfg.period[7:0]       <= rx_byte;
          `REG_SOFT_TRIG:  o_soft_trig             <= rx_byte[0];
          `REG_CONT:       o_cfg.continuous        <= rx_byte[0];
          `REG_ADC_DIV:    o_adc_div               <= rx_byte;
          `REG_TRIG_COUNT: o_cfg.trig_count        <= rx_byte;
          `REG_PTR_RESET:  o_ptr_reset             <= rx_byte[0];
          default: ;  // unmapped address, value thrown away
        endcase
      end
    end
  end

  // one value byte can only ever hit one address
  a_strobes_exclusive: assert property (@(posedge pll_clk128) disable iff (!reset)
    !(o_soft_trig && o_ptr_reset));

endmodule

// ==== hw/pulse_sequencer.sv ====
//////////////////////////////
// shot sequencer
// trigger edge detect, shot counter,
// continuous burst repeat, pon / poff
// and acquisition window decode
//////////////////////////////
module pulse_sequencer (
  input  logic                 pll_clk128,
  input  logic                 reset,
  input  pulser_pkg::seq_cfg_t i_cfg,
  input  logic                 i_trig_ext,
  input  logic                 i_soft_trig,
  output logic                 o_pon,
  output logic                 o_poff,
  output logic                 o_acq_window,
  output logic                 o_busy,
  output pulser_pkg::byte_t    o_shot_idx
);
  import pulser_pkg::*;

  seq_state_e state;
  period_t    counter;      // 0 when idle, 1..period during a shot
  logic       trig_q;       // registered copy of the pin
  logic       trig_prev;
  logic       trig_evt;
  logic       shot_end;
  logic       repeat_shot;

  ////////////////////////////// trigger
  always_ff @(posedge pll_clk128 or negedge reset) begin
    if (!reset) begin
      trig_q    <= 1'b0;
      trig_prev <= 1'b0;
    end else begin
      trig_q    <= i_trig_ext;
      trig_prev <= trig_q;
    end
  end

  assign trig_evt = (trig_q && !trig_prev) || i_soft_trig;

  assign shot_end = (counter == i_cfg.period);
  // more shots left in the burst, compared on 9 bits so trig_count 0 gives one shot
  assign repeat_shot = i_cfg.continuous &&
                       (({1'b0, o_shot_idx} + 9'd1) < {1'b0, i_cfg.trig_count});

  ////////////////////////////// shot fsm
  always_ff @(posedge pll_clk128 or negedge reset) begin
    if (!reset) begin
      state      <= SEQ_IDLE;
      counter    <= '0;
      o_shot_idx <= '0;
    end else begin
      case (state)
        SEQ_IDLE: begin
          if (trig_evt) begin
            state      <= SEQ_SHOT;
            counter    <= period_t'(1);
            o_shot_idx <= '0;         // new burst
          end
        end
        SEQ_SHOT: begin
          if (!shot_end) begin
            counter <= counter + period_t'(1);
          end else if (repeat_shot) begin
            counter    <= period_t'(1);  // next shot back to back
            o_shot_idx <= o_shot_idx + byte_t'(1);
          end else begin
            state   <= SEQ_IDLE;
            counter <= '0;
          end
        end
        default: begin
          state   <= SEQ_IDLE;
          counter <= '0;
        end
      endcase
    end
  end

  ////////////////////////////// gate decode
  assign o_pon = (counter != '0) && (counter <= period_t'(i_cfg.pon_len));

  // damping gate is active low
  assign o_poff = !((counter > period_t'(i_cfg.pon_poff)) &&
                    (counter < period_t'(i_cfg.poff_end)));

  assign o_acq_window = (counter > period_t'(i_cfg.acq_delay)) &&
                        (counter < period_t'(i_cfg.acq_end));

  assign o_busy = (state == SEQ_SHOT);

  a_idle_cnt_zero: assert property (@(posedge pll_clk128) disable iff (!reset)
    (state == SEQ_IDLE) |-> (counter == '0));

  // the register file must not move the period under a running shot
  a_cnt_in_period: assert property (@(posedge pll_clk128) disable iff (!reset)
    counter <= i_cfg.period);

endmodule

// ==== hw/acq_sampler.sv ====
//////////////////////////////
// acquisition sampler
// adc clock divider inside the window,
// tagged sample word, sram write pointer
//////////////////////////////
`include "pulser_defs.svh"

module acq_sampler (
  input  logic                    pll_clk128,
  input  logic                    reset,
  input  logic                    i_acq_window,
  input  pulser_pkg::byte_t       i_adc_div,
  input  pulser_pkg::byte_t       i_shot_idx,
  input  logic                    i_ptr_reset,
  input  pulser_pkg::adc_sample_t i_adc,
  input  logic                    i_top_tour1,
  input  logic                    i_top_tour2,
  output logic                    o_adc_clk,
  output pulser_pkg::ram_addr_t   o_ram_addr,
  output pulser_pkg::ram_word_t   o_ram_data,
  output logic                    o_ram_we_n
);
  import pulser_pkg::*;

  byte_t     div_cnt;
  ram_addr_t wr_ptr;        // next free sram location
  ram_word_t sample_word;
  logic      div_wrap;      // half period done
  logic      adc_rise;

  assign div_wrap = i_acq_window && (div_cnt == i_adc_div);
  assign adc_rise = div_wrap && !o_adc_clk;

  ////////////////////////////// adc clock
  always_ff @(posedge pll_clk128 or negedge reset) begin
    if (!reset) begin
      div_cnt   <= '0;
      o_adc_clk <= 1'b0;
    end else if (!i_acq_window) begin
      div_cnt   <= '0;    // clock parked low outside the window
      o_adc_clk <= 1'b0;
    end else if (div_wrap) begin
      div_cnt   <= '0;
      o_adc_clk <= !o_adc_clk;
    end else begin
      div_cnt <= div_cnt + byte_t'(1);
    end
  end

  // tag, shot index, encoder, adc msbs, gap bit, adc lsbs
  assign sample_word = {`SAMPLE_TAG, i_shot_idx[1:0], i_top_tour2, i_top_tour1,
                        i_adc[9:7], 1'b0, i_adc[6:0]};

  ////////////////////////////// sram write
  always_ff @(posedge pll_clk128 or negedge reset) begin
    if (!reset) begin
      wr_ptr     <= '0;
      o_ram_addr <= '0;
      o_ram_data <= '0;
    end else begin
      if (adc_rise) begin
        o_ram_addr <= wr_ptr;
        o_ram_data <= sample_word;
        wr_ptr     <= wr_ptr + ram_addr_t'(1);
      end
      if (i_ptr_reset) begin
        wr_ptr <= '0;     // host restarts the buffer
      end
    end
  end

  // write strobe follows the adc clock, held off outside the window
  assign o_ram_we_n = i_acq_window ? o_adc_clk : 1'b1;

  a_no_write_outside: assert property (@(posedge pll_clk128) disable iff (!reset)
    !i_acq_window |-> o_ram_we_n);

endmodule

// ==== hw/pulser_top.sv ====
//////////////////////////////
// pulser top level
// register file, shot sequencer and
// sampler wired to the pins
//////////////////////////////
module pulser_top (
  input  logic                    pll_clk128,
  input  logic                    reset,
  input  pulser_pkg::spi_rx_t     i_spi_rx,
  input  logic                    i_trig_ext,
  input  pulser_pkg::adc_sample_t i_adc,
  input  logic                    i_top_tour1,
  input  logic                    i_top_tour2,
  output logic                    o_pon,
  output logic                    o_poff,
  output logic                    o_adc_clk,
  output pulser_pkg::ram_addr_t   o_ram_addr,
  output pulser_pkg::ram_word_t   o_ram_data,
  output logic                    o_ram_we_n,
  output logic                    o_acq_led
);
  import pulser_pkg::*;

  seq_cfg_t cfg;
  byte_t    adc_div;
  byte_t    shot_idx;
  logic     soft_trig;    // one-cycle strobes from the register file
  logic     ptr_reset;
  logic     acq_window;

  cfg_regs u_cfg (
    .pll_clk128  (pll_clk128),
    .reset       (reset),
    .i_spi_rx    (i_spi_rx),
    .o_cfg       (cfg),
    .o_adc_div   (adc_div),
    .o_soft_trig (soft_trig),
    .o_ptr_reset (ptr_reset)
  );

  pulse_sequencer u_seq (
    .pll_clk128   (pll_clk128),
    .reset        (reset),
    .i_cfg        (cfg),
    .i_trig_ext   (i_trig_ext),
    .i_soft_trig  (soft_trig),
    .o_pon        (o_pon),
    .o_poff       (o_poff),
    .o_acq_window (acq_window),
    .o_busy       (o_acq_led),    // led lit for the whole burst
    .o_shot_idx   (shot_idx)
  );

  acq_sampler u_sampler (
    .pll_clk128   (pll_clk128),
    .reset        (reset),
    .i_acq_window (acq_window),
    .i_adc_div    (adc_div),
    .i_shot_idx   (shot_idx),
    .i_ptr_reset  (ptr_reset),
    .i_adc        (i_adc),
    .i_top_tour1  (i_top_tour1),
    .i_top_tour2  (i_top_tour2),
    .o_adc_clk    (o_adc_clk),
    .o_ram_addr   (o_ram_addr),
    .o_ram_data   (o_ram_data),
    .o_ram_we_n   (o_ram_we_n)
  );

endmodule

// ==== tb/tb_pulser.sv ====
//////////////////////////////
// pulser testbench
// clock, reset, byte driver, lcg stimulus,
// reference model, compare tasks, test sequence
//////////////////////////////
`include "pulser_defs.svh"

module tb_pulser;
  import pulser_pkg::*;

  logic        pll_clk128;
  logic        reset;
  spi_rx_t     spi_rx;
  logic        i_trig_ext;
  adc_sample_t i_adc;
  logic        i_top_tour1;
  logic        i_top_tour2;
  logic        o_pon;
  logic        o_poff;
  logic        o_adc_clk;
  ram_addr_t   o_ram_addr;
  ram_word_t   o_ram_data;
  logic        o_ram_we_n;
  logic        o_acq_led;

  seq_cfg_t    exp_cfg;       // register file as the host wrote it
  byte_t       exp_div;
  ram_addr_t   exp_addr;      // next sram address expected
  logic [31:0] lcg_state;
  logic        soft_pulse;    // soft trigger value byte on the bus
  int          value_errs;
  int          other_errs;

  // monitor state
  period_t     m_cnt;
  byte_t       m_shot;
  byte_t       shot_q;
  logic [1:0]  evt_q;         // trigger events, two cycles of history
  logic        trig_q;
  logic        adc_clk_q;
  adc_sample_t adc_q;
  logic        tour1_q;
  logic        tour2_q;
  int          m_words;
  int          busy_run;
  int          last_busy;
  logic [3:0]  shots_seen;

  pulser_top u_dut (
    .pll_clk128  (pll_clk128),
    .reset       (reset),
    .i_spi_rx    (spi_rx),
    .i_trig_ext  (i_trig_ext),
    .i_adc       (i_adc),
    .i_top_tour1 (i_top_tour1),
    .i_top_tour2 (i_top_tour2),
    .o_pon       (o_pon),
    .o_poff      (o_poff),
    .o_adc_clk   (o_adc_clk),
    .o_ram_addr  (o_ram_addr),
    .o_ram_data  (o_ram_data),
    .o_ram_we_n  (o_ram_we_n),
    .o_acq_led   (o_acq_led)
  );

  initial begin
    pll_clk128 = 1'b0;
    forever #20 pll_clk128 = !pll_clk128;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  ////////////////////////////// reference
  function automatic logic ref_pon(input seq_cfg_t cfg, input period_t cnt);
    int c;
    c = int'(cnt);
    return (c >= 1) && (c <= int'(cfg.pon_len));
  endfunction

  function automatic logic ref_poff(input seq_cfg_t cfg, input period_t cnt);
    int c;
    c = int'(cnt);
    if ((c > int'(cfg.pon_poff)) && (c < int'(cfg.poff_end))) return 1'b0;  // damping on
    return 1'b1;
  endfunction

  function automatic logic ref_window(input seq_cfg_t cfg, input period_t cnt);
    int c;
    c = int'(cnt);
    return (c > int'(cfg.acq_delay)) && (c < int'(cfg.acq_end));
  endfunction

  function automatic ram_word_t ref_word(input adc_sample_t adc, input logic t1,
                                         input logic t2, input byte_t shot);
    ram_word_t w;
    w       = '0;
    w[15]   = `SAMPLE_TAG;
    w[14:13] = shot[1:0];
    w[12]   = t2;
    w[11]   = t1;
    w[10:8] = adc[9:7];
    w[6:0]  = adc[6:0];    // bit 7 stays zero
    return w;
  endfunction

  // rising adc clock edges that fit in one window
  function automatic int ref_words(input seq_cfg_t cfg, input byte_t div);
    int win_len;
    int halves;
    win_len = int'(cfg.acq_end) - int'(cfg.acq_delay) - 1;
    if (win_len < 0) win_len = 0;
    halves = win_len / (int'(div) + 1);
    return (halves + 1) / 2;
  endfunction

  ////////////////////////////// compare tasks
  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERROR t=%0t %s got %0b expected %0b", $time, name, got, exp);
      value_errs++;
    end
  endtask

  task automatic check_addr(input string name, input ram_addr_t got, input ram_addr_t exp);
    if (got !== exp) begin
      $display("ERROR t=%0t %s got %0h expected %0h", $time, name, got, exp);
      value_errs++;
    end
  endtask

  task automatic check_word(input string name, input ram_word_t got, input ram_word_t exp);
    if (got !== exp) begin
      $display("ERROR t=%0t %s got %0h expected %0h", $time, name, got, exp);
      value_errs++;
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("ERROR t=%0t %s got %0d expected %0d", $time, name, got, exp);
      value_errs++;
    end
  endtask

  ////////////////////////////// stimulus
  always @(posedge pll_clk128) begin
    #2;
    lcg_state   = lcg_next(lcg_state);
    i_adc       = adc_sample_t'(lcg_state[25:16]);
    i_top_tour1 = lcg_state[27];
    i_top_tour2 = lcg_state[28];
  end

  // one valid cycle, then three idle cycles
  task automatic send_byte(input byte_t data, input logic is_soft);
    @(posedge pll_clk128);
    #2;
    spi_rx.data  = data;
    spi_rx.valid = 1'b1;
    soft_pulse   = is_soft;
    @(posedge pll_clk128);
    #2;
    spi_rx.valid = 1'b0;
    soft_pulse   = 1'b0;
    repeat (2) @(posedge pll_clk128);
  endtask

  task automatic write_reg(input byte_t addr, input byte_t value);
    send_byte(`PULSER_SYNC_BYTE, 1'b0);
    send_byte(addr, 1'b0);
    send_byte(value, (addr == `REG_SOFT_TRIG) && value[0]);
    case (addr)
      `REG_PON_POFF:   exp_cfg.pon_poff = value;
      `REG_PON:        exp_cfg.pon_len = value;
      `REG_POFF_H:     exp_cfg.poff_end[15:8] = value;
      `REG_POFF_L:     exp_cfg.poff_end[7:0] = value;
      `REG_DELAY_H:    exp_cfg.acq_delay[15:8] = value;
      `REG_DELAY_L:    exp_cfg.acq_delay[7:0] = value;
      `REG_ACQ_H:      exp_cfg.acq_end[15:8] = value;
      `REG_ACQ_L:      exp_cfg.acq_end[7:0] = value;
      `REG_PERIOD_U:   exp_cfg.period[23:16] = value;
      `REG_PERIOD_H:   exp_cfg.period[15:8] = value;
      `REG_PERIOD_L:   exp_cfg.period[7:0] = value;
      `REG_CONT:       exp_cfg.continuous = value[0];
      `REG_ADC_DIV:    exp_div = value;
      `REG_TRIG_COUNT: exp_cfg.trig_count = value;
      `REG_PTR_RESET:  if (value[0]) exp_addr = '0;
      default: ;
    endcase
  endtask

  task automatic wait_busy(input logic level, input int limit);
    int n;
    n = 0;
    while (o_acq_led !== level && n < limit) begin
      @(negedge pll_clk128);
      n++;
    end
    if (o_acq_led !== level) begin
      $display("timeout: o_acq_led did not reach %0b within %0d cycles", level, limit);
      other_errs++;
    end
    @(posedge pll_clk128);
    #2;
  endtask

  task automatic fire_ext_trigger();
    @(posedge pll_clk128);
    #2;
    i_trig_ext = 1'b1;
    wait_busy(1'b1, 8);
    i_trig_ext = 1'b0;
  endtask

  ////////////////////////////// monitor
  always @(negedge pll_clk128) begin
    if (!reset) begin
      m_cnt      = '0;
      m_shot     = '0;
      shot_q     = '0;
      evt_q      = '0;
      trig_q     = 1'b0;
      adc_clk_q  = 1'b0;
      adc_q      = '0;
      tour1_q    = 1'b0;
      tour2_q    = 1'b0;
      m_words    = 0;
      busy_run   = 0;
      last_busy  = 0;
      shots_seen = '0;
    end else begin
      // word built from inputs held over the edge that raised the adc clock
      if (o_adc_clk && !adc_clk_q) begin
        check_word("o_ram_data", o_ram_data, ref_word(adc_q, tour1_q, tour2_q, shot_q));
        check_addr("o_ram_addr", o_ram_addr, exp_addr);
        exp_addr = exp_addr + ram_addr_t'(1);
        m_words++;
        shots_seen[o_ram_data[14:13]] = 1'b1;  // shot field of the stored word
      end
      if (m_cnt == '0) begin
        if (evt_q[1]) begin   // two cycles from event to counter 1
          m_cnt  = period_t'(1);
          m_shot = '0;
        end
      end else if (m_cnt == exp_cfg.period) begin
        check_count("words per shot", m_words, ref_words(exp_cfg, exp_div));
        m_words = 0;
        if (exp_cfg.continuous && (int'(m_shot) + 1 < int'(exp_cfg.trig_count))) begin
          m_cnt  = period_t'(1);
          m_shot = m_shot + byte_t'(1);
        end else begin
          m_cnt = '0;
        end
      end else begin
        m_cnt = m_cnt + period_t'(1);
      end
      check_bit("o_pon", o_pon, ref_pon(exp_cfg, m_cnt));
      check_bit("o_poff", o_poff, ref_poff(exp_cfg, m_cnt));
      check_bit("o_acq_led", o_acq_led, m_cnt != '0);
      if (!ref_window(exp_cfg, m_cnt)) check_bit("o_ram_we_n", o_ram_we_n, 1'b1);
      if (o_acq_led) begin
        busy_run++;
      end else if (busy_run != 0) begin
        last_busy = busy_run;
        busy_run  = 0;
      end
      evt_q     = {evt_q[0], (i_trig_ext && !trig_q) || soft_pulse};
      trig_q    = i_trig_ext;
      adc_clk_q = o_adc_clk;
      adc_q     = i_adc;
      tour1_q   = i_top_tour1;
      tour2_q   = i_top_tour2;
      shot_q    = m_shot;
    end
  end

  task automatic finish_run();
    $display("checks done: %0d value errors, %0d other errors", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  endtask

  ////////////////////////////// test sequence
  initial begin
    reset       = 1'b0;
    spi_rx      = '0;
    i_trig_ext  = 1'b0;
    i_adc       = '0;
    i_top_tour1 = 1'b0;
    i_top_tour2 = 1'b0;
    soft_pulse  = 1'b0;
    value_errs  = 0;
    other_errs  = 0;
    lcg_state   = 32'ha564;
    exp_cfg.pon_len    = `DEF_PON_LEN;
    exp_cfg.pon_poff   = `DEF_PON_POFF;
    exp_cfg.poff_end   = `DEF_POFF_END;
    exp_cfg.acq_delay  = `DEF_ACQ_DELAY;
    exp_cfg.acq_end    = `DEF_ACQ_END;
    exp_cfg.period     = `DEF_PERIOD;
    exp_cfg.trig_count = `DEF_TRIG_COUNT;
    exp_cfg.continuous = `DEF_CONTINUOUS;
    exp_div  = `DEF_ADC_DIV;
    exp_addr = '0;
    repeat (16) @(posedge pll_clk128);
    #2;
    reset = 1'b1;

    @(negedge pll_clk128);
    check_bit("o_poff", o_poff, 1'b1);
    check_bit("o_pon", o_pon, 1'b0);
    check_bit("o_ram_we_n", o_ram_we_n, 1'b1);
    check_bit("o_acq_led", o_acq_led, 1'b0);
    check_addr("o_ram_addr", o_ram_addr, '0);
    check_word("o_ram_data", o_ram_data, '0);

    // short shot, 80 cycles, window 15..59
    write_reg(`REG_PON, 8'd4);
    write_reg(`REG_PON_POFF, 8'd5);
    write_reg(`REG_POFF_H, 8'd0);
    write_reg(`REG_POFF_L, 8'd12);
    write_reg(`REG_DELAY_H, 8'd0);
    write_reg(`REG_DELAY_L, 8'd14);
    write_reg(`REG_ACQ_H, 8'd0);
    write_reg(`REG_ACQ_L, 8'd60);
    write_reg(`REG_PERIOD_U, 8'd0);
    write_reg(`REG_PERIOD_H, 8'd0);
    write_reg(`REG_PERIOD_L, 8'd80);
    write_reg(`REG_ADC_DIV, 8'd2);
    fire_ext_trigger();
    wait_busy(1'b0, 200);
    check_count("busy cycles, single shot", last_busy, 80);

    // continuous burst of three from a soft trigger
    write_reg(`REG_CONT, 8'h01);
    write_reg(`REG_TRIG_COUNT, 8'd3);
    shots_seen = '0;
    write_reg(`REG_SOFT_TRIG, 8'h01);
    wait_busy(1'b1, 8);
    wait_busy(1'b0, 300);
    check_count("busy cycles, burst", last_busy, 240);
    check_count("shot indices in words", int'(shots_seen), 7);

    // pointer reset, then junk that must change nothing
    write_reg(`REG_CONT, 8'h00);
    write_reg(`REG_PTR_RESET, 8'h01);
    send_byte(8'h55, 1'b0);
    send_byte(`REG_PON, 1'b0);
    send_byte(8'h7F, 1'b0);
    write_reg(8'h42, 8'h99);
    fire_ext_trigger();
    wait_busy(1'b0, 200);
    check_count("busy cycles, after junk", last_busy, 80);
    check_addr("o_ram_addr", o_ram_addr, ram_addr_t'(ref_words(exp_cfg, exp_div) - 1));
    repeat (4) @(posedge pll_clk128);
    finish_run();
  end

endmodule

// ==== verilog.f ====
+incdir+hw
hw/pulser_pkg.sv
hw/cfg_regs.sv
hw/pulse_sequencer.sv
hw/acq_sampler.sv
hw/pulser_top.sv
tb/tb_pulser.sv

// ==== Makefile ====
# Verilator build and run for the pulser testbench

VERILATOR  ?= verilator
TOP        ?= tb_pulser
FILELIST   ?= verilog.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing
PASS_MSG   ?= RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
